// ==== filelist.f ====
src/rv_core_pkg.sv
src/stage_link.sv
src/idu_opcode.sv
src/regfile.sv
src/idu.sv
src/exu.sv
src/wbu.sv
src/rv_core.sv
verif/tb_rv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --timescale 1ns/10ps \
    --top-module tb_rv_core -f filelist.f -o sim_rv_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_rv_core)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

// ==== src/exu.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu import rv_core_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    stage_link.sink   dec_in,
    stage_link.source exe_out
);

    dec_payload_t    din;
    exe_payload_t    dout;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] alu_out;
    logic [XLEN-1:0] next_pc;
    logic            taken;

    assign din      = dec_in.payload;
    assign rs1      = din.rs1_val;
    assign rs2      = din.rs2_val;
    assign imm      = din.imm;
    assign pc_plus4 = dec_in.pc + 32'd4;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ALU
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (dec_in.inst_num)
            inst_auipc: alu_out = dec_in.pc + imm;
            inst_jal,
            inst_jalr:  alu_out = pc_plus4;    // Link value
            inst_lb, inst_lbu, inst_lw, inst_sb, inst_sw,
            inst_addi:  alu_out = rs1 + imm;
            inst_slti:  alu_out = {{(XLEN-1){1'b0}}, $signed(rs1) < $signed(imm)};
            inst_xori:  alu_out = rs1 ^ imm;
            inst_ori:   alu_out = rs1 | imm;
            inst_andi:  alu_out = rs1 & imm;
            inst_slli:  alu_out = rs1 << imm[4:0];
            inst_srli:  alu_out = rs1 >> imm[4:0];
            inst_add:   alu_out = rs1 + rs2;
            inst_sub:   alu_out = rs1 - rs2;
            inst_xor:   alu_out = rs1 ^ rs2;
            inst_or:    alu_out = rs1 | rs2;
            inst_and:   alu_out = rs1 & rs2;
            inst_sll:   alu_out = rs1 << rs2[4:0];
            inst_srl:   alu_out = rs1 >> rs2[4:0];
            inst_slt:   alu_out = {{(XLEN-1){1'b0}}, $signed(rs1) < $signed(rs2)};
            default:    alu_out = '0;
        endcase
    end

    always_comb begin
        case (dec_in.inst_num)
            inst_beq: taken = (rs1 == rs2);
            inst_bne: taken = (rs1 != rs2);
            inst_blt: taken = ($signed(rs1) < $signed(rs2));
            inst_bge: taken = ($signed(rs1) >= $signed(rs2));
            default:  taken = 1'b0;
        endcase
    end

    always_comb begin
        if (dec_in.inst_num == inst_jalr)
            next_pc = (rs1 + imm) & ~32'd1;
        else if (dec_in.inst_num == inst_jal || taken)
            next_pc = dec_in.pc + imm;
        else
            next_pc = pc_plus4;
    end

    assign dout = {din.rd, alu_out, rs2, next_pc};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            exe_out.valid <= 1'b0;
        else
            exe_out.valid <= dec_in.valid;
    end

    always_ff @(posedge clk) begin
        if (dec_in.valid) begin
            exe_out.pc       <= dec_in.pc;
            exe_out.inst_num <= dec_in.inst_num;
            exe_out.payload  <= dout;
        end
    end

endmodule

`default_nettype wire

// ==== src/idu.sv ====
`timescale 1ns/10ps
`default_nettype none

module idu import rv_core_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  inst_req,
    input  logic [XLEN-1:0]       inst,
    input  logic [XLEN-1:0]       pc,
    input  logic                  inst_ack,
    input  logic                  halted,
    output logic [REG_ADDR_W-1:0] rs1_addr,
    output logic [REG_ADDR_W-1:0] rs2_addr,
    input  logic [XLEN-1:0]       rs1_data,
    input  logic [XLEN-1:0]       rs2_data,
    stage_link.source             dec_out
);

    logic                  busy;
    logic                  pend;
    logic                  accept;
    logic [XLEN-1:0]       inst_q;
    logic [XLEN-1:0]       pc_q;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    inst_num_e             beq_num;
    inst_num_e             lb_num;
    inst_num_e             sb_num;
    inst_num_e             addi_num;
    inst_num_e             add_num;
    inst_num_e             inst_num;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm;

    // One request per handshake, none while busy, acknowledging or halted
    assign accept = inst_req && !busy && !inst_ack && !halted;
    assign funct3 = inst_q[14:12];
    assign funct7 = inst_q[31:25];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            pend <= 1'b0;
        end else begin
            pend <= accept;
            if (accept)
                busy <= 1'b1;
            else if (inst_ack)
                busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            inst_q <= inst;
            pc_q   <= pc;    // Same value as the pc committed by wbu
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Funct3/funct7 resolution per opcode family
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (funct3)
            3'b000:  beq_num = inst_beq;
            3'b001:  beq_num = inst_bne;
            3'b100:  beq_num = inst_blt;
            3'b101:  beq_num = inst_bge;
            default: beq_num = inst_inv;
        endcase
        case (funct3)
            3'b000:  lb_num = inst_lb;
            3'b010:  lb_num = inst_lw;
            3'b100:  lb_num = inst_lbu;
            default: lb_num = inst_inv;
        endcase
        case (funct3)
            3'b000:  sb_num = inst_sb;
            3'b010:  sb_num = inst_sw;
            default: sb_num = inst_inv;
        endcase
        case (funct3)
            3'b000:  addi_num = inst_addi;
            3'b010:  addi_num = inst_slti;
            3'b100:  addi_num = inst_xori;
            3'b110:  addi_num = inst_ori;
            3'b111:  addi_num = inst_andi;
            3'b001:  addi_num = (funct7 == 7'b0) ? inst_slli : inst_inv;
            3'b101:  addi_num = (funct7 == 7'b0) ? inst_srli : inst_inv;    // srai is not kept
            default: addi_num = inst_inv;
        endcase
        case ({funct7, funct3})
            10'b0000000_000: add_num = inst_add;
            10'b0100000_000: add_num = inst_sub;
            10'b0000000_001: add_num = inst_sll;
            10'b0000000_010: add_num = inst_slt;
            10'b0000000_100: add_num = inst_xor;
            10'b0000000_101: add_num = inst_srl;
            10'b0000000_110: add_num = inst_or;
            10'b0000000_111: add_num = inst_and;
            default:         add_num = inst_inv;
        endcase
    end

    idu_opcode u_idu_opcode (
        .inst          (inst_q),
        .inst_beq_num  (beq_num),
        .inst_lb_num   (lb_num),
        .inst_sb_num   (sb_num),
        .inst_addi_num (addi_num),
        .inst_add_num  (add_num),
        .inst_num      (inst_num),
        .inst_type     (),
        .rd            (rd),
        .rs1           (rs1_addr),
        .rs2           (rs2_addr),
        .imm           (imm)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            dec_out.valid <= 1'b0;
        else
            dec_out.valid <= pend;
    end

    always_ff @(posedge clk) begin
        if (pend) begin
            dec_out.pc       <= pc_q;
            dec_out.inst_num <= inst_num;
            dec_out.payload  <= {rd, rs1_data, rs2_data, imm};
        end
    end

endmodule

`default_nettype wire

// ==== src/idu_opcode.sv ====
`timescale 1ns/10ps
`default_nettype none

module idu_opcode import rv_core_pkg::*; (
    input  logic [XLEN-1:0]       inst,
    input  inst_num_e             inst_beq_num,
    input  inst_num_e             inst_lb_num,
    input  inst_num_e             inst_sb_num,
    input  inst_num_e             inst_addi_num,
    input  inst_num_e             inst_add_num,
    output inst_num_e             inst_num,
    output inst_type_e            inst_type,
    output logic [REG_ADDR_W-1:0] rd,
    output logic [REG_ADDR_W-1:0] rs1,
    output logic [REG_ADDR_W-1:0] rs2,
    output logic [XLEN-1:0]       imm
);

    logic [OPCODE_W-1:0] opcode;

    assign opcode = inst[OPCODE_W-1:0];

    // Funct-dependent families take their number from the resolver in idu
    always_comb begin
        case (opcode)
            OP_AUIPC:  inst_num = inst_auipc;
            OP_JAL:    inst_num = inst_jal;
            OP_JALR:   inst_num = inst_jalr;
            OP_BRANCH: inst_num = inst_beq_num;
            OP_LOAD:   inst_num = inst_lb_num;
            OP_STORE:  inst_num = inst_sb_num;
            OP_IMM:    inst_num = inst_addi_num;
            OP_REG:    inst_num = inst_add_num;
            OP_SYSTEM: inst_num = inst_ebreak;    // Only member of the system group here
            default:   inst_num = inst_inv;
        endcase
    end

    always_comb begin
        case (opcode)
            OP_AUIPC:  inst_type = type_u;
            OP_JAL:    inst_type = type_j;
            OP_JALR:   inst_type = type_i;
            OP_BRANCH: inst_type = type_b;
            OP_LOAD:   inst_type = type_i;
            OP_STORE:  inst_type = type_s;
            OP_IMM:    inst_type = type_i;
            OP_REG:    inst_type = type_r;
            OP_SYSTEM: inst_type = type_i;
            default:   inst_type = type_n;
        endcase
    end

    assign rd  = inst[11:7];
    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];

    // Immediate layout follows the format, always sign-extended from bit 31
    always_comb begin
        case (inst_type)
            type_i:  imm = {{20{inst[31]}}, inst[31:20]};
            type_s:  imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            type_b:  imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            type_u:  imm = {inst[31:12], 12'b0};
            type_j:  imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

module regfile import rv_core_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [REG_ADDR_W-1:0] rs1_addr,
    input  logic [REG_ADDR_W-1:0] rs2_addr,
    output logic [XLEN-1:0]       rs1_data,
    output logic [XLEN-1:0]       rs2_data,
    input  logic                  we,
    input  logic [REG_ADDR_W-1:0] waddr,
    input  logic [XLEN-1:0]       wdata
);

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin    // x0 is never written
            regs[waddr] <= wdata;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// ==== src/rv_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_core import rv_core_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  inst_req,
    input  logic [XLEN-1:0]       inst,
    output logic                  inst_ack,
    output logic [XLEN-1:0]       pc,
    output logic                  wb_valid,
    output logic [REG_ADDR_W-1:0] wb_rd,
    output logic [XLEN-1:0]       wb_data,
    output logic                  halted
);

    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]       rf_wdata;

    stage_link #(.payload_t(dec_payload_t)) dec_link ();
    stage_link #(.payload_t(exe_payload_t)) exe_link ();

    idu u_idu (
        .clk      (clk),
        .arst_n   (arst_n),
        .inst_req (inst_req),
        .inst     (inst),
        .pc       (pc),
        .inst_ack (inst_ack),
        .halted   (halted),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .dec_out  (dec_link.source)
    );

    regfile u_regfile (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (rf_we),
        .waddr    (rf_waddr),
        .wdata    (rf_wdata)
    );

    exu u_exu (
        .clk     (clk),
        .arst_n  (arst_n),
        .dec_in  (dec_link.sink),
        .exe_out (exe_link.source)
    );

    wbu u_wbu (
        .clk      (clk),
        .arst_n   (arst_n),
        .exe_in   (exe_link.sink),
        .inst_req (inst_req),
        .pc       (pc),
        .inst_ack (inst_ack),
        .halted   (halted),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .rf_we    (rf_we),
        .rf_waddr (rf_waddr),
        .rf_wdata (rf_wdata)
    );

endmodule

`default_nettype wire

// ==== src/rv_core_pkg.sv ====
`default_nettype none

package rv_core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W   = 7;
    localparam int DMEM_BYTES = 64;
    localparam int DMEM_AW    = $clog2(DMEM_BYTES);
    localparam int NUM_REGS   = 2 ** REG_ADDR_W;

    // Major opcodes of the supported RV32I subset
    localparam logic [OPCODE_W-1:0] OP_AUIPC  = 7'b0010111;
    localparam logic [OPCODE_W-1:0] OP_JAL    = 7'b1101111;
    localparam logic [OPCODE_W-1:0] OP_JALR   = 7'b1100111;
    localparam logic [OPCODE_W-1:0] OP_BRANCH = 7'b1100011;
    localparam logic [OPCODE_W-1:0] OP_LOAD   = 7'b0000011;
    localparam logic [OPCODE_W-1:0] OP_STORE  = 7'b0100011;
    localparam logic [OPCODE_W-1:0] OP_IMM    = 7'b0010011;
    localparam logic [OPCODE_W-1:0] OP_REG    = 7'b0110011;
    localparam logic [OPCODE_W-1:0] OP_SYSTEM = 7'b1110011;

    typedef enum logic [4:0] {
        inst_inv,
        inst_auipc, inst_jal, inst_jalr,
        inst_beq, inst_bne, inst_blt, inst_bge,
        inst_lb, inst_lbu, inst_lw, inst_sb, inst_sw,
        inst_addi, inst_slti, inst_xori, inst_ori, inst_andi, inst_slli, inst_srli,
        inst_add, inst_sub, inst_xor, inst_or, inst_and, inst_sll, inst_srl, inst_slt,
        inst_ebreak
    } inst_num_e;

    typedef enum logic [2:0] {
        type_r, type_i, type_s, type_b, type_u, type_j, type_n
    } inst_type_e;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       rs1_val;
        logic [XLEN-1:0]       rs2_val;
        logic [XLEN-1:0]       imm;
    } dec_payload_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       alu_out;    // Also the effective address of loads and stores
        logic [XLEN-1:0]       store_data;
        logic [XLEN-1:0]       next_pc;
    } exe_payload_t;

endpackage

`default_nettype wire

// ==== src/stage_link.sv ====
`timescale 1ns/10ps
`default_nettype none

interface stage_link import rv_core_pkg::*; #(
    parameter type payload_t = dec_payload_t
) ();

    logic            valid;    // One-cycle pulse per instruction
    logic [XLEN-1:0] pc;
    inst_num_e       inst_num;
    payload_t        payload;

    modport source (output valid, output pc, output inst_num, output payload);
    modport sink   (input valid, input pc, input inst_num, input payload);

endinterface

`default_nettype wire

// ==== src/wbu.sv ====
`timescale 1ns/10ps
`default_nettype none

module wbu import rv_core_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    stage_link.sink               exe_in,
    input  logic                  inst_req,
    output logic [XLEN-1:0]       pc,
    output logic                  inst_ack,
    output logic                  halted,
    output logic                  wb_valid,
    output logic [REG_ADDR_W-1:0] wb_rd,
    output logic [XLEN-1:0]       wb_data,
    output logic                  rf_we,
    output logic [REG_ADDR_W-1:0] rf_waddr,
    output logic [XLEN-1:0]       rf_wdata
);

    exe_payload_t       ein;
    logic [7:0]         dmem [DMEM_BYTES];
    logic [DMEM_AW-1:0] addr;
    logic [XLEN-1:0]    load_word;
    logic               writes_rd;
    logic               is_store;

    assign ein  = exe_in.payload;
    assign addr = ein.alu_out[DMEM_AW-1:0];    // Wraps modulo the memory size

    assign load_word = {dmem[addr + DMEM_AW'(3)], dmem[addr + DMEM_AW'(2)],
                        dmem[addr + DMEM_AW'(1)], dmem[addr]};

    assign is_store  = exe_in.inst_num inside {inst_sb, inst_sw};
    assign writes_rd = !(exe_in.inst_num inside {inst_inv, inst_beq, inst_bne, inst_blt,
                                                 inst_bge, inst_sb, inst_sw, inst_ebreak});

    always_comb begin
        case (exe_in.inst_num)
            inst_lb:  rf_wdata = {{(XLEN-8){load_word[7]}}, load_word[7:0]};
            inst_lbu: rf_wdata = {{(XLEN-8){1'b0}}, load_word[7:0]};
            inst_lw:  rf_wdata = load_word;
            default:  rf_wdata = ein.alu_out;
        endcase
    end

    assign rf_we    = exe_in.valid && writes_rd;
    assign rf_waddr = ein.rd;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Data memory, little endian bytes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DMEM_BYTES; i++) begin
                dmem[i] <= '0;
            end
        end else if (exe_in.valid && is_store) begin
            dmem[addr] <= ein.store_data[7:0];
            if (exe_in.inst_num == inst_sw) begin
                dmem[addr + DMEM_AW'(1)] <= ein.store_data[15:8];
                dmem[addr + DMEM_AW'(2)] <= ein.store_data[23:16];
                dmem[addr + DMEM_AW'(3)] <= ein.store_data[31:24];
            end
        end
    end

    // Retire, pc commit and the acknowledge half of the fetch handshake
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc       <= '0;
            inst_ack <= 1'b0;
            halted   <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= rf_we;
            if (exe_in.valid) begin
                pc       <= ein.next_pc;
                inst_ack <= 1'b1;
            end else if (!inst_req) begin
                inst_ack <= 1'b0;    // Released once the request drops
            end
            if (exe_in.valid && exe_in.inst_num == inst_ebreak)
                halted <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rf_we) begin
            wb_rd   <= rf_waddr;
            wb_data <= rf_wdata;
        end
    end

endmodule

`default_nettype wire

// ==== verif/stim_prog.txt ====
// Columns: pc, instruction, flag (0 no register write, 1 writes rd, 2 must never run), rd, data
// All values in hex; registers and data memory start at zero
00000000 00500093 1 01 00000005  // addi x1, x0, 5
00000004 ffd00113 1 02 fffffffd  // addi x2, x0, -3
00000008 002081b3 1 03 00000002  // add  x3, x1, x2
0000000c 40110233 1 04 fffffff8  // sub  x4, x2, x1
00000010 001122b3 1 05 00000001  // slt  x5, x2, x1
00000014 fff0a313 1 06 00000000  // slti x6, x1, -1
00000018 00409393 1 07 00000050  // slli x7, x1, 4
0000001c 01c15413 1 08 0000000f  // srli x8, x2, 28
00000020 fff0c493 1 09 fffffffa  // xori x9, x1, -1
00000024 00708013 1 00 0000000c  // addi x0, x1, 7
00000028 0083e533 1 0a 0000005f  // or   x10, x7, x8
0000002c 0f357593 1 0b 00000053  // andi x11, x10, 0xf3
00000030 00309633 1 0c 00000014  // sll  x12, x1, x3
00000034 00318463 0 00 00000000  // beq  x3, x3, +8 taken
00000038 00100f93 2 1f 00000001  // skipped
0000003c fe109ee3 0 00 00000000  // bne  x1, x1, -4 not taken
00000040 00114463 0 00 00000000  // blt  x2, x1, +8 taken
00000044 00100f93 2 1f 00000001  // skipped
00000048 fe20cee3 0 00 00000000  // blt  x1, x2, -4 not taken
0000004c 0020d463 0 00 00000000  // bge  x1, x2, +8 taken
00000050 00100f93 2 1f 00000001  // skipped
00000054 fe115ee3 0 00 00000000  // bge  x2, x1, -4 not taken
00000058 fe208ce3 0 00 00000000  // beq  x1, x2, -8 not taken
0000005c 00209463 0 00 00000000  // bne  x1, x2, +8 taken
00000060 00100f93 2 1f 00000001  // skipped
00000064 008006ef 1 0d 00000068  // jal  x13, +8
00000068 00100f93 2 1f 00000001  // skipped
0000006c 00001717 1 0e 0000106c  // auipc x14, 1
00000070 011687e7 1 0f 00000074  // jalr x15, 0x11(x13) lands on 0x78
00000074 00100f93 2 1f 00000001  // skipped
00000078 00402423 0 00 00000000  // sw   x4, 8(x0)
0000007c fe918fa3 0 00 00000000  // sb   x9, -1(x3)
00000080 00100803 1 10 fffffffa  // lb   x16, 1(x0)
00000084 00104883 1 11 000000fa  // lbu  x17, 1(x0)
00000088 00802903 1 12 fffffff8  // lw   x18, 8(x0)
0000008c 00002983 1 13 0000fa00  // lw   x19, 0(x0)
00000090 12345ab7 0 00 00000000  // lui  x21 is not supported
00000094 001a8b13 1 16 00000001  // addi x22, x21, 1
00000098 00100073 0 00 00000000  // ebreak

// ==== verif/tb_rv_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core import rv_core_pkg::*; ();

    localparam int CLK_PERIOD      = 20;
    localparam int DRIVE_DELAY     = 2;
    localparam int RESET_CYCLES    = 5;
    localparam int MAX_LINES       = 64;
    localparam int COLS            = 5;    // pc, instruction, flag, rd, data
    localparam int CYCLES_PER_LINE = 12;
    localparam int ACK_DELAY       = 3;
    localparam int ACK_HOLD        = 3;    // Cycles the request stays high into the ack
    localparam int HALT_WAIT       = 10;
    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;
    localparam logic [31:0] NOP_WORD    = 32'h0000_0013;

    logic                  clk;
    logic                  arst_n;
    logic                  inst_req;
    logic [XLEN-1:0]       inst;
    logic                  inst_ack;
    logic [XLEN-1:0]       pc;
    logic                  wb_valid;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_data;
    logic                  halted;

    logic [31:0] stim [MAX_LINES*COLS];
    int          run_count [MAX_LINES];
    int          n_lines;
    int          limit;
    int          cycle_count;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          seed = 32'h8090_10bf;
    int          wb_seen;
    logic [31:0] rd_seen;
    logic [31:0] data_seen;
    logic        stop_run;

    rv_core u_dut (
        .clk      (clk),
        .arst_n   (arst_n),
        .inst_req (inst_req),
        .inst     (inst),
        .inst_ack (inst_ack),
        .pc       (pc),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .halted   (halted)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (limit > 0 && cycle_count >= limit) begin
            $display("ERROR at %0t: run did not finish within %0d cycles", $time, limit);
            $display("sim failed");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;    // Outputs are settled here and inputs change here
    endtask

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH at %0t: %s expected %0h actual %0h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors != errors_before)
            tests_failed++;
        $display("test %s: %s", name, (errors == errors_before) ? "ok" : "FAILED");
    endtask

    task automatic sample_retire();
        if (wb_valid) begin
            wb_seen++;
            rd_seen   = 32'(wb_rd);
            data_seen = wb_data;
        end
    endtask

    function automatic int find_line(input logic [31:0] addr);
        int found;
        found = -1;
        for (int i = 0; i < n_lines; i++) begin
            if (found < 0 && stim[i*COLS] == addr)
                found = i;
        end
        return found;
    endfunction

    task automatic load_program();
        for (int i = 0; i < MAX_LINES*COLS; i++) begin
            stim[i] = ~32'(i);    // Bit 31 set marks a word the file left alone
        end
        $readmemh("verif/stim_prog.txt", stim);
        n_lines = 0;
        for (int i = 0; i < MAX_LINES; i++) begin
            run_count[i] = 0;
            if (n_lines == i && !stim[i*COLS][31])
                n_lines = i + 1;
        end
        assert (n_lines > 0) else begin
            $display("ERROR: the program file holds no lines");
            errors++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic reset_state_test();
        int errors_before;
        errors_before = errors;
        expect_value("pc", pc, 32'd0);
        expect_value("inst_ack", 32'(inst_ack), 32'd0);
        expect_value("wb_valid", 32'(wb_valid), 32'd0);
        expect_value("halted", 32'(halted), 32'd0);
        report_test("reset state", errors_before);
    endtask

    // One full four-phase fetch of the line whose pc the core asks for
    task automatic run_instruction();
        int          idx;
        int          pause;
        int          edges;
        int          errors_before;
        logic [31:0] flag;
        logic [31:0] line_pc;
        errors_before = errors;
        wb_seen = 0;    // A late retire of the previous handshake counts here
        pause = $unsigned($random(seed)) % 4;
        repeat (pause) begin
            next_cycle();
            sample_retire();
        end
        line_pc = pc;
        idx = find_line(line_pc);
        assert (idx >= 0) else begin
            $display("ERROR at %0t: pc %08h has no line in the program", $time, line_pc);
            errors++;
        end
        if (idx < 0) begin
            stop_run = 1'b1;
        end else begin
            flag = stim[idx*COLS + 2];
            run_count[idx]++;
            assert (flag != 32'd2) else begin
                $display("ERROR at %0t: pc %08h should have been jumped over", $time, line_pc);
                errors++;
            end
            assert (run_count[idx] == 1) else begin
                $display("ERROR at %0t: pc %08h fetched a second time", $time, line_pc);
                errors++;
            end
            inst     = stim[idx*COLS + 1];
            inst_req = 1'b1;
            edges    = 0;
            while (!inst_ack) begin
                next_cycle();
                sample_retire();
                edges++;
            end
            expect_value("inst_ack delay", 32'(edges - 1), 32'(ACK_DELAY));
            repeat (ACK_HOLD) begin    // A held request must not start a second fetch
                next_cycle();
                sample_retire();
                expect_value("inst_ack", 32'(inst_ack), 32'd1);
            end
            inst_req = 1'b0;
            edges    = 0;
            while (inst_ack) begin
                next_cycle();
                sample_retire();
                edges++;
            end
            expect_value("inst_ack release", 32'(edges), 32'd1);
            expect_value("wb_valid pulses", 32'(wb_seen), (flag == 32'd1) ? 32'd1 : 32'd0);
            if (flag == 32'd1 && wb_seen == 1) begin
                expect_value("wb_rd", rd_seen, stim[idx*COLS + 3]);
                expect_value("wb_data", data_seen, stim[idx*COLS + 4]);
            end
            expect_value("halted", 32'(halted), (inst == EBREAK_WORD) ? 32'd1 : 32'd0);
            if (flag == 32'd2)
                stop_run = 1'b1;
        end
        report_test($sformatf("pc %08h inst %08h", line_pc, inst), errors_before);
    endtask

    task automatic halt_test();
        int   errors_before;
        logic acked;
        errors_before = errors;
        acked    = 1'b0;
        wb_seen  = 0;
        inst     = NOP_WORD;
        inst_req = 1'b1;
        repeat (HALT_WAIT) begin
            next_cycle();
            sample_retire();
            if (inst_ack)
                acked = 1'b1;
        end
        inst_req = 1'b0;
        assert (!acked) else begin
            $display("ERROR at %0t: a request was acknowledged after halt", $time);
            errors++;
        end
        expect_value("wb_valid pulses", 32'(wb_seen), 32'd0);
        report_test("halt blocks fetch", errors_before);
    endtask

    task automatic coverage_test();
        int errors_before;
        errors_before = errors;
        for (int i = 0; i < n_lines; i++) begin
            if (stim[i*COLS + 2] != 32'd2) begin
                assert (run_count[i] == 1) else begin
                    $display("ERROR: pc %08h ran %0d times instead of once",
                             stim[i*COLS], run_count[i]);
                    errors++;
                end
            end
        end
        report_test("every program line ran once", errors_before);
    endtask

    initial begin
        clk      = 1'b0;
        arst_n   = 1'b0;
        inst_req = 1'b0;
        inst     = '0;
        stop_run = 1'b0;
        load_program();
        limit = n_lines * CYCLES_PER_LINE + RESET_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        arst_n = 1'b1;
        reset_state_test();

        while (!halted && !stop_run) begin
            run_instruction();
        end
        assert (halted) else begin
            $display("ERROR at %0t: program stopped before ebreak halted the core", $time);
            errors++;
        end
        if (halted)
            halt_test();
        coverage_test();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
